//--- vlog.f
rtl/link_pkg.sv
rtl/cfg_pkg.sv
rtl/llink_cfg_regs.sv
rtl/llink_auto_sync.sv
rtl/llink_stream_pack.sv
rtl/llink_phy_concat.sv
rtl/llink_top.sv
bench/llink_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the logic link testbench with Verilator and runs it.
# Exits nonzero when the build fails, the simulation aborts,
# or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module llink_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vllink_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

exit 0

//--- bench/llink_tb.sv
/*
  Testbench for the logic link top level. Loops tx_phy back to rx_phy,
  drives random stream words and Wishbone accesses, and checks the DUT
  with concurrent assertions against a small model of the link timing.
*/
`timescale 1ns/1ns

module llink_tb;
  import link_pkg::*;
  import cfg_pkg::*;

  // Tests need about 300 cycles
  localparam int          MAX_CYCLES     = 2000;
  localparam logic [7:0]  CORRUPT_CYCLES = 8'd6;

  logic                      clk_wr;
  logic                      reset;
  logic                      tx_online;
  logic                      rx_online;
  stream_t                   dstrm;
  stream_t                   ustrm;
  chan_word_t [NUM_CHAN-1:0] tx_phy;
  chan_word_t [NUM_CHAN-1:0] rx_phy;
  wb_req_t                   wb_req;
  wb_rsp_t                   wb_rsp;
  logic                      corrupt;

  int seed = 68307;
  int fail_count = 0;
  int test_num = 0;
  int fails_before = 0;
  int cycle_count = 0;

  // Expected read data while ack is high
  logic        rd_check;
  logic [15:0] rd_expect;

  // Register values as last written
  logic [15:0] cur_delay_x = RESET_DELAY;
  logic [15:0] cur_delay_y = RESET_DELAY;
  logic [15:0] cur_delay_z = RESET_DELAY;
  logic [1:0]  cur_mrk = 2'b00;
  logic        cur_stb_en = 1'b0;

  // Link model
  logic [15:0] tx_edges;
  logic [15:0] rx_edges;
  logic [15:0] on_idx;
  logic        exp_tx_dly;
  logic        exp_rx_dly;
  logic        exp_stb;
  logic        stb_q;
  logic [2:0]  tx_dly_hist;
  logic        rx_dly_q;
  stream_t     dstrm_hist [4];

  llink_top llink_top_inst (
    .clk_wr    (clk_wr),
    .reset     (reset),
    .tx_online (tx_online),
    .rx_online (rx_online),
    .dstrm     (dstrm),
    .ustrm     (ustrm),
    .tx_phy    (tx_phy),
    .rx_phy    (rx_phy),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp)
  );

  initial begin
    clk_wr = 1'b0;
    forever #20 clk_wr = ~clk_wr;
  end

  // Loopback that can flip the channel 2 marker
  always_comb begin
    rx_phy = tx_phy;
    if (corrupt) begin
      rx_phy[2].marker = ~tx_phy[2].marker;
    end
  end

  ////////////////////
  // Model

  assign exp_tx_dly = tx_edges >= cur_delay_x;
  assign exp_rx_dly = rx_edges >= cur_delay_y;
  // Strobe on the first online cycle and every delay_z cycles after
  assign exp_stb = exp_tx_dly && cur_stb_en &&
                   (cur_delay_z < 16'd2 || (on_idx % cur_delay_z) == 16'd0);

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_edges    <= '0;
      rx_edges    <= '0;
      on_idx      <= '0;
      stb_q       <= 1'b0;
      tx_dly_hist <= '0;
      rx_dly_q    <= 1'b0;
    end else begin
      if (!tx_online) begin
        tx_edges <= '0;
      end else if (tx_edges != 16'hffff) begin
        tx_edges <= tx_edges + 16'd1;
      end
      if (!(tx_online && rx_online && exp_tx_dly)) begin
        rx_edges <= '0;
      end else if (rx_edges != 16'hffff) begin
        rx_edges <= rx_edges + 16'd1;
      end
      on_idx      <= exp_tx_dly ? on_idx + 16'd1 : 16'd0;
      stb_q       <= exp_stb;
      tx_dly_hist <= {tx_dly_hist[1:0], exp_tx_dly};
      rx_dly_q    <= exp_rx_dly;
    end
  end

  always_ff @(posedge clk_wr) begin
    dstrm_hist[0] <= dstrm;
    for (int i = 1; i < 4; i++) begin
      dstrm_hist[i] <= dstrm_hist[i-1];
    end
  end

  ////////////////////
  // Helpers

  task automatic record_failure(input string msg);
    fail_count++;
    $display("FAIL at %0t ns: %s", $time, msg);
  endtask

  function automatic logic ctl_bits_ok(input chan_word_t [NUM_CHAN-1:0] phy,
                                       input logic stb, input logic [1:0] mrk);
    logic ok;
    ok = 1'b1;
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      if (phy[ch].strobe != stb || phy[ch].marker != mrk) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  function automatic logic [15:0] status_word(input logic tx_up, input logic rx_up,
                                              input logic [7:0] errs);
    status_t s;
    s = '0;
    s.tx_online_delay = tx_up;
    s.rx_online_delay = rx_up;
    s.align_err_count = errs;
    return s;
  endfunction

  function automatic stream_t random_word();
    stream_t     w;
    logic [31:0] r;
    r = $random(seed);
    w.state      = r[3:0];
    w.protid     = r[7:4];
    w.crc        = r[15:8];
    w.dvalid     = r[16];
    w.crc_valid  = r[17];
    w.valid      = r[16] | r[18];
    w.data[63:32] = $random(seed);
    w.data[31:0]  = $random(seed);
    return w;
  endfunction

  task automatic write_register(input logic [2:0] addr, input logic [15:0] data);
    userbits_t bits;
    @(negedge clk_wr);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: data};
    do @(negedge clk_wr); while (!wb_rsp.ack);
    wb_req = '0;
    bits = userbits_t'(data);
    case (addr)
      REG_DELAY_X: cur_delay_x = data;
      REG_DELAY_Y: cur_delay_y = data;
      REG_DELAY_Z: cur_delay_z = data;
      REG_USERBITS: begin
        cur_mrk    = bits.mrk_userbit;
        cur_stb_en = bits.stb_enable;
      end
      default: ;
    endcase
    @(negedge clk_wr);
  endtask

  task automatic check_register(input logic [2:0] addr, input logic [15:0] expected);
    @(negedge clk_wr);
    rd_expect = expected;
    rd_check  = 1'b1;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: 16'h0000};
    do @(negedge clk_wr); while (!wb_rsp.ack);
    wb_req = '0;
    @(negedge clk_wr);
    rd_check = 1'b0;
  endtask

  task automatic wait_tx_online();
    int n;
    n = 0;
    while (tx_phy[0].marker != cur_mrk && n < 40) begin
      @(negedge clk_wr);
      n++;
    end
    if (n == 40) begin
      fail_count++;
      $display("Error: tx_phy markers did not appear within 40 cycles");
    end
  endtask

  task automatic finish_test(input string name);
    test_num++;
    $display("Test %0d %s: %0d failures", test_num, name, fail_count - fails_before);
    fails_before = fail_count;
  endtask

  ////////////////////
  // Checks

  ack_one_cycle: assert property (@(posedge clk_wr) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack)
    else record_failure("wishbone ack high for two cycles");

  ack_after_req: assert property (@(posedge clk_wr) disable iff (reset)
    (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack)
    else record_failure("wishbone ack missing after request");

  read_data: assert property (@(posedge clk_wr) disable iff (reset)
    (wb_rsp.ack && rd_check) |-> wb_rsp.dat == rd_expect)
    else record_failure($sformatf("read data %h, expected %h", wb_rsp.dat, rd_expect));

  phy_idle: assert property (@(posedge clk_wr) disable iff (reset)
    !tx_dly_hist[0] |-> tx_phy == '0)
    else record_failure("tx_phy not zero while offline");

  phy_ctl: assert property (@(posedge clk_wr) disable iff (reset)
    tx_dly_hist[0] |-> ctl_bits_ok(tx_phy, stb_q, cur_mrk))
    else record_failure("tx_phy strobe or marker wrong");

  ustrm_masked: assert property (@(posedge clk_wr) disable iff (reset)
    !rx_dly_q |-> !(ustrm.valid || ustrm.dvalid || ustrm.crc_valid))
    else record_failure("ustrm valid while rx offline");

  loopback_data: assert property (@(posedge clk_wr) disable iff (reset)
    (rx_dly_q && tx_dly_hist[2]) |-> ustrm == dstrm_hist[3])
    else record_failure("ustrm differs from dstrm of 4 cycles earlier");

  ////////////////////
  // Stimulus

  always @(negedge clk_wr) begin
    dstrm = random_word();
  end

  initial begin
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk_wr);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    reset     = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    dstrm     = '0;
    wb_req    = '0;
    corrupt   = 1'b0;
    rd_check  = 1'b0;
    rd_expect = '0;
    repeat (8) @(posedge clk_wr);
    @(negedge clk_wr);
    reset = 1'b0;

    write_register(REG_DELAY_X, 16'd5);
    write_register(REG_DELAY_Y, 16'd3);
    write_register(REG_DELAY_Z, 16'd7);
    write_register(REG_USERBITS, 16'h0006);
    check_register(REG_DELAY_X, 16'd5);
    check_register(REG_DELAY_Y, 16'd3);
    check_register(REG_DELAY_Z, 16'd7);
    check_register(REG_USERBITS, 16'h0006);
    // Status writes are ignored and unmapped reads return zero
    write_register(REG_STATUS, 16'hffff);
    check_register(REG_STATUS, status_word(1'b0, 1'b0, 8'd0));
    check_register(3'd5, 16'h0000);
    check_register(3'd7, 16'h0000);
    finish_test("register write and readback");

    @(negedge clk_wr);
    tx_online = 1'b1;
    wait_tx_online();
    check_register(REG_STATUS, status_word(1'b1, 1'b0, 8'd0));
    @(negedge clk_wr);
    rx_online = 1'b1;
    repeat (cur_delay_y + 16'd2) @(negedge clk_wr);
    check_register(REG_STATUS, status_word(1'b1, 1'b1, 8'd0));
    finish_test("online delays");

    repeat (150) @(negedge clk_wr);
    finish_test("loopback random data");

    @(negedge clk_wr);
    tx_online = 1'b0;
    rx_online = 1'b0;
    repeat (3) @(negedge clk_wr);
    write_register(REG_DELAY_Z, 16'd3);
    write_register(REG_USERBITS, 16'h0005);
    check_register(REG_USERBITS, 16'h0005);
    @(negedge clk_wr);
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_tx_online();
    repeat (30) @(negedge clk_wr);
    finish_test("strobe period and markers");

    @(negedge clk_wr);
    corrupt = 1'b1;
    repeat (CORRUPT_CYCLES) @(negedge clk_wr);
    corrupt = 1'b0;
    repeat (3) @(negedge clk_wr);
    check_register(REG_STATUS, status_word(1'b1, 1'b1, CORRUPT_CYCLES));
    // Link drop takes the rx side down with the tx side
    @(negedge clk_wr);
    tx_online = 1'b0;
    repeat (6) @(negedge clk_wr);
    check_register(REG_STATUS, status_word(1'b0, 1'b0, CORRUPT_CYCLES));
    finish_test("alignment errors and link drop");

    $display("Summary: %0d tests run, %0d checks failed", test_num, fail_count);
    if (fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- rtl/llink_top.sv
/*
  Logic link top level. Connects the register block, auto sync,
  stream pack and PHY concat blocks between the stream and the PHY channels.
*/
`timescale 1ns/1ns

module llink_top (
  input  logic                                          clk_wr,
  input  logic                                          reset,
  input  logic                                          tx_online,
  input  logic                                          rx_online,
  input  link_pkg::stream_t                             dstrm,
  output link_pkg::stream_t                             ustrm,
  output link_pkg::chan_word_t [link_pkg::NUM_CHAN-1:0] tx_phy,
  input  link_pkg::chan_word_t [link_pkg::NUM_CHAN-1:0] rx_phy,
  input  cfg_pkg::wb_req_t                              wb_req,
  output cfg_pkg::wb_rsp_t                              wb_rsp
);
  import link_pkg::*;
  import cfg_pkg::*;

  sync_cfg_t  sync_cfg;
  link_word_t tx_link;
  link_word_t rx_link;
  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       stb_bit;
  logic [1:0] mrk_bits;
  logic       align_err;

  ////////////////////
  // Control

  llink_cfg_regs llink_cfg_regs_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .wb_req          (wb_req),
    .wb_rsp          (wb_rsp),
    .sync_cfg        (sync_cfg),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .align_err       (align_err)
  );

  llink_auto_sync llink_auto_sync_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .sync_cfg        (sync_cfg),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .stb_bit         (stb_bit),
    .mrk_bits        (mrk_bits)
  );

  ////////////////////
  // Datapath

  llink_stream_pack llink_stream_pack_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .dstrm           (dstrm),
    .ustrm           (ustrm),
    .tx_link         (tx_link),
    .rx_link         (rx_link),
    .rx_online_delay (rx_online_delay)
  );

  llink_phy_concat llink_phy_concat_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_link         (tx_link),
    .rx_link         (rx_link),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .tx_online_delay (tx_online_delay),
    .stb_bit         (stb_bit),
    .mrk_bits        (mrk_bits),
    .align_err       (align_err)
  );

endmodule

//--- rtl/llink_phy_concat.sv
/*
  Splits link words across the PHY channels with strobe and marker bits,
  and rebuilds received link words while checking channel alignment.
*/
`timescale 1ns/1ns

module llink_phy_concat (
  input  logic                                          clk_wr,
  input  logic                                          reset,
  input  link_pkg::link_word_t                          tx_link,
  output link_pkg::link_word_t                          rx_link,
  output link_pkg::chan_word_t [link_pkg::NUM_CHAN-1:0] tx_phy,
  input  link_pkg::chan_word_t [link_pkg::NUM_CHAN-1:0] rx_phy,
  input  logic                                          tx_online_delay,
  input  logic                                          stb_bit,
  input  logic [1:0]                                    mrk_bits,
  output logic                                          align_err
);
  import link_pkg::*;

  logic [LINK_W-1:0] tx_flat;
  logic [LINK_W-1:0] rx_flat;
  logic              mismatch;

  assign tx_flat = tx_link;

  ////////////////////
  // Transmit

  // Channel 0 carries the low payload bits
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy <= '0;
    end else begin
      for (int ch = 0; ch < NUM_CHAN; ch++) begin
        if (tx_online_delay) begin
          tx_phy[ch].payload <= tx_flat[ch*CHAN_PAYLOAD_W +: CHAN_PAYLOAD_W];
          tx_phy[ch].strobe  <= stb_bit;
          tx_phy[ch].marker  <= mrk_bits;
        end else begin
          tx_phy[ch] <= '0;
        end
      end
    end
  end

  ////////////////////
  // Receive

  always_comb begin
    rx_flat  = '0;
    mismatch = 1'b0;
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      rx_flat[ch*CHAN_PAYLOAD_W +: CHAN_PAYLOAD_W] = rx_phy[ch].payload;
      // All channels must agree with channel 0
      if (rx_phy[ch].strobe != rx_phy[0].strobe) begin
        mismatch = 1'b1;
      end
      if (rx_phy[ch].marker != rx_phy[0].marker) begin
        mismatch = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    rx_link <= link_word_t'(rx_flat);
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      align_err <= 1'b0;
    end else begin
      align_err <= mismatch;
    end
  end

endmodule

//--- rtl/llink_stream_pack.sv
/*
  Registers the downstream stream into a link word, and the received
  link word back into the upstream stream, masking valids while offline.
*/
`timescale 1ns/1ns

module llink_stream_pack (
  input  logic                 clk_wr,
  input  logic                 reset,
  input  link_pkg::stream_t    dstrm,
  output link_pkg::stream_t    ustrm,
  output link_pkg::link_word_t tx_link,
  input  link_pkg::link_word_t rx_link,
  input  logic                 rx_online_delay
);

  ////////////////////
  // Downstream

  always_ff @(posedge clk_wr) begin
    tx_link.strm <= dstrm;
    tx_link.pad  <= 1'b0;
  end

  ////////////////////
  // Upstream

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      ustrm <= '0;
    end else begin
      ustrm <= rx_link.strm;
      // Nothing is valid until the receive side is online
      if (!rx_online_delay) begin
        ustrm.valid     <= 1'b0;
        ustrm.dvalid    <= 1'b0;
        ustrm.crc_valid <= 1'b0;
      end
    end
  end

  dvalid_needs_valid: assert property (@(posedge clk_wr) disable iff (reset)
    ustrm.dvalid |-> ustrm.valid)
    else $error("ustrm dvalid without valid");

endmodule

//--- rtl/llink_auto_sync.sv
/*
  Delays the TX and RX online levels by the configured edge counts and
  generates the persistent strobe and marker user bits for the PHY words.
*/
`timescale 1ns/1ns

module llink_auto_sync (
  input  logic               clk_wr,
  input  logic               reset,
  input  logic               tx_online,
  input  logic               rx_online,
  input  cfg_pkg::sync_cfg_t sync_cfg,
  output logic               tx_online_delay,
  output logic               rx_online_delay,
  output logic               stb_bit,
  output logic [1:0]         mrk_bits
);

  typedef enum logic [1:0] {
    SYNC_IDLE,
    SYNC_TX_WAIT,
    SYNC_RX_WAIT,
    SYNC_ONLINE
  } sync_state_e;

  sync_state_e state;
  logic [15:0] cnt;
  logic [15:0] cnt_inc;
  logic [15:0] per_cnt;
  logic [15:0] stb_reload;

  assign cnt_inc = cnt + 16'd1;

  ////////////////////
  // Online sequencing

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      state <= SYNC_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        // Count consecutive tx_online edges from a zero count in idle
        SYNC_IDLE, SYNC_TX_WAIT: begin
          if (!tx_online) begin
            state <= SYNC_IDLE;
            cnt   <= '0;
          end else if (cnt_inc >= sync_cfg.delay_x) begin
            state <= SYNC_RX_WAIT;
            cnt   <= '0;
          end else begin
            state <= SYNC_TX_WAIT;
            cnt   <= cnt_inc;
          end
        end
        SYNC_RX_WAIT: begin
          if (!tx_online) begin
            state <= SYNC_IDLE;
            cnt   <= '0;
          end else if (!rx_online) begin
            cnt <= '0;
          end else if (cnt_inc >= sync_cfg.delay_y) begin
            state <= SYNC_ONLINE;
            cnt   <= '0;
          end else begin
            cnt <= cnt_inc;
          end
        end
        default: begin
          if (!tx_online) begin
            state <= SYNC_IDLE;
          end else if (!rx_online) begin
            state <= SYNC_RX_WAIT;
          end
        end
      endcase
    end
  end

  assign tx_online_delay = (state == SYNC_RX_WAIT) || (state == SYNC_ONLINE);
  assign rx_online_delay = (state == SYNC_ONLINE);

  ////////////////////
  // Persistent strobe

  // A delay_z of 0 or 1 strobes every cycle
  assign stb_reload = (sync_cfg.delay_z > 16'd1) ? sync_cfg.delay_z - 16'd1 : '0;

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      per_cnt <= '0;
    end else if (!tx_online_delay) begin
      per_cnt <= '0;
    end else if (per_cnt == '0) begin
      per_cnt <= stb_reload;
    end else begin
      per_cnt <= per_cnt - 16'd1;
    end
  end

  assign stb_bit  = tx_online_delay && sync_cfg.stb_enable && (per_cnt == '0);
  assign mrk_bits = tx_online_delay ? sync_cfg.mrk_userbit : 2'b00;

  rx_after_tx: assert property (@(posedge clk_wr) disable iff (reset)
    $rose(rx_online_delay) |-> $past(tx_online_delay))
    else $error("rx_online_delay rose without tx_online_delay");

endmodule

//--- rtl/llink_cfg_regs.sv
/*
  Wishbone classic slave for the logic link.
  Holds the sync delays and user bits and reports online and alignment status.
*/
`timescale 1ns/1ns

module llink_cfg_regs (
  input  logic               clk_wr,
  input  logic               reset,
  input  cfg_pkg::wb_req_t   wb_req,
  output cfg_pkg::wb_rsp_t   wb_rsp,
  output cfg_pkg::sync_cfg_t sync_cfg,
  input  logic               tx_online_delay,
  input  logic               rx_online_delay,
  input  logic               align_err
);
  import cfg_pkg::*;

  reg_addr_e   addr;
  userbits_t   wr_bits;
  status_t     status;
  logic        req_fire;
  logic        ack_q;
  logic [15:0] rd_data;
  logic [15:0] rd_q;
  logic [7:0]  err_count;

  assign addr    = reg_addr_e'(wb_req.adr);
  assign wr_bits = userbits_t'(wb_req.dat);

  // Sample a new access only while not acking the last one
  assign req_fire = wb_req.cyc && wb_req.stb && !ack_q;

  always_comb begin
    status                 = '0;
    status.tx_online_delay = tx_online_delay;
    status.rx_online_delay = rx_online_delay;
    status.align_err_count = err_count;
  end

  ////////////////////
  // Read mux

  always_comb begin
    case (addr)
      REG_DELAY_X:  rd_data = sync_cfg.delay_x;
      REG_DELAY_Y:  rd_data = sync_cfg.delay_y;
      REG_DELAY_Z:  rd_data = sync_cfg.delay_z;
      REG_USERBITS: rd_data = {13'd0, sync_cfg.stb_enable, sync_cfg.mrk_userbit};
      REG_STATUS:   rd_data = status;
      default:      rd_data = '0;
    endcase
  end

  ////////////////////
  // Config registers

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      sync_cfg.delay_x     <= RESET_DELAY;
      sync_cfg.delay_y     <= RESET_DELAY;
      sync_cfg.delay_z     <= RESET_DELAY;
      sync_cfg.mrk_userbit <= 2'b00;
      sync_cfg.stb_enable  <= 1'b0;
    end else if (req_fire && wb_req.we) begin
      case (addr)
        REG_DELAY_X: sync_cfg.delay_x <= wb_req.dat;
        REG_DELAY_Y: sync_cfg.delay_y <= wb_req.dat;
        REG_DELAY_Z: sync_cfg.delay_z <= wb_req.dat;
        REG_USERBITS: begin
          sync_cfg.mrk_userbit <= wr_bits.mrk_userbit;
          sync_cfg.stb_enable  <= wr_bits.stb_enable;
        end
        // Status is read only
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_fire;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (req_fire) begin
      rd_q <= rd_data;
    end
  end

  // Saturating alignment error count
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      err_count <= '0;
    end else if (align_err && err_count != 8'hff) begin
      err_count <= err_count + 8'd1;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rd_q;

  ack_single_cycle: assert property (@(posedge clk_wr) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("wishbone ack held for two cycles");

endmodule

//--- rtl/cfg_pkg.sv
/*
  Wishbone bus types, register map and status layout for the
  logic link configuration block.
*/
package cfg_pkg;

  localparam logic [15:0] RESET_DELAY = 16'd4;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [15:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [15:0] dat;
  } wb_rsp_t;

  typedef enum logic [2:0] {
    REG_DELAY_X  = 3'd0,
    REG_DELAY_Y  = 3'd1,
    REG_DELAY_Z  = 3'd2,
    REG_USERBITS = 3'd3,
    REG_STATUS   = 3'd4
  } reg_addr_e;

  typedef struct packed {
    logic [15:0] delay_x;
    logic [15:0] delay_y;
    logic [15:0] delay_z;
    logic [1:0]  mrk_userbit;
    logic        stb_enable;
  } sync_cfg_t;

  // REG_USERBITS data word
  typedef struct packed {
    logic [12:0] rsvd;
    logic        stb_enable;
    logic [1:0]  mrk_userbit;
  } userbits_t;

  // REG_STATUS data word
  typedef struct packed {
    logic [5:0] rsvd;
    logic       tx_online_delay;
    logic       rx_online_delay;
    logic [7:0] align_err_count;
  } status_t;

endpackage

//--- rtl/link_pkg.sv
/*
  Stream, link-word and PHY channel-word types for the logic link.
  Shared by the pack, concat and top level blocks and by the testbench.
*/
package link_pkg;

  ////////////////////
  // Channel geometry

  localparam int NUM_CHAN       = 4;
  localparam int CHAN_W         = 24;
  // Strobe and two marker bits ride on top of the payload
  localparam int CHAN_PAYLOAD_W = CHAN_W - 3;
  localparam int LINK_W         = NUM_CHAN * CHAN_PAYLOAD_W;

  ////////////////////
  // Stream and link words

  // Same layout upstream and downstream, 83 bits
  typedef struct packed {
    logic [3:0]  state;
    logic [3:0]  protid;
    logic [63:0] data;
    logic        dvalid;
    logic [7:0]  crc;
    logic        crc_valid;
    logic        valid;
  } stream_t;

  // One stream word plus a pad bit fills the link exactly
  typedef struct packed {
    stream_t strm;
    logic    pad;
  } link_word_t;

  typedef struct packed {
    logic [CHAN_PAYLOAD_W-1:0] payload;
    logic                      strobe;
    logic [1:0]                marker;
  } chan_word_t;

endpackage
